// File: Bender.yml
package:
  name: uart_tx

sources:
  - src/uart_pkg.sv
  - src/contador_m.sv
  - src/uart_fd.sv
  - src/uart_uc.sv
  - src/hexa7seg.sv
  - src/uart.sv
  - target: test
    files:
      - bench/uart_monitor.sv
      - bench/tb_uart.sv

// File: bench/tb_uart.sv
`timescale 1ns/10ps

module tb_uart;

    import uart_pkg::*;

    localparam int M = 16;
    localparam int N = 5;
    localparam int random_count = 8;

    logic   clock;
    logic   arst_n;
    logic   partida;
    ascii_t dados_ascii;
    logic   saida_serial;
    logic   pronto;
    logic   db_tick;
    logic   db_partida;
    logic   db_saida_serial;
    seg7_t  db_estado;

    string       golden_names[$];
    ascii_t      golden_values[$];
    bit          golden_repeat[$];
    int          bench_errors = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          frames_sent = 0;
    logic [31:0] rng_state = 32'h7716;

    uart #(
        .M (M),
        .N (N)
    ) uut (
        .clock           (clock),
        .arst_n          (arst_n),
        .partida         (partida),
        .dados_ascii     (dados_ascii),
        .saida_serial    (saida_serial),
        .pronto          (pronto),
        .db_tick         (db_tick),
        .db_partida      (db_partida),
        .db_saida_serial (db_saida_serial),
        .db_estado       (db_estado)
    );

    uart_monitor #(
        .M (M)
    ) frame_check (
        .clock           (clock),
        .arst_n          (arst_n),
        .partida         (partida),
        .saida_serial    (saida_serial),
        .pronto          (pronto),
        .db_tick         (db_tick),
        .db_partida      (db_partida),
        .db_saida_serial (db_saida_serial),
        .db_estado       (db_estado)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #50 clock = ~clock;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic load_golden();
        int               fd;
        int               code;
        bit               done;
        string            tok;
        ascii_t           value;
        int               flag;
        logic [8*128-1:0] rest;
        fd = $fopen("bench/uart_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/uart_golden.txt");
            bench_errors++;
        end else begin
            done = 0;
            while (!done) begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1) begin
                    done = 1;
                end else if (tok.substr(0, 0) == "#") begin
                    // skip the rest of a comment line
                    code = $fgets(rest, fd);
                end else begin
                    code = $fscanf(fd, "%h %d", value, flag);
                    if (code != 2) begin
                        $display("golden line for test %s could not be read", tok);
                        bench_errors++;
                        done = 1;
                    end else begin
                        golden_names.push_back(tok);
                        golden_values.push_back(value);
                        golden_repeat.push_back(flag != 0);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic wait_pronto(input string name);
        int waited;
        waited = 0;
        while (pronto !== 1'b1 && waited < 10 * M + 20) begin
            @(negedge clock);
            waited++;
        end
        if (pronto !== 1'b1) begin
            $display("no pronto for test %s", name);
            bench_errors++;
        end
    endtask

    task automatic send_frame(input string name, input ascii_t value, input bit repeat_mid);
        frame_check.expect_frame(name, value);
        frames_sent++;
        @(posedge clock);
        #10;
        dados_ascii = value;
        partida     = 1'b1;
        @(posedge clock);
        #10;
        partida = 1'b0;
        if (repeat_mid) begin
            // second pulse half way through, other data on the bus
            repeat (5 * M - 1) @(posedge clock);
            #10;
            dados_ascii = ~value;
            partida     = 1'b1;
            @(posedge clock);
            #10;
            partida = 1'b0;
        end
        wait_pronto(name);
    endtask

    initial begin
        arst_n      = 1'b0;
        partida     = 1'b0;
        dados_ascii = '0;
        load_golden();
        cycle_limit = (golden_names.size() + random_count + 2) * (10 * M + 20);
        repeat (2) @(posedge clock);
        #10;
        arst_n = 1'b1;
        // a few idle cycles before the first start
        repeat (4) @(posedge clock);
        for (int i = 0; i < golden_names.size(); i++) begin
            send_frame(golden_names[i], golden_values[i], golden_repeat[i]);
        end
        for (int i = 0; i < random_count; i++) begin
            rng_state = xorshift(rng_state);
            send_frame($sformatf("xorshift_%0d", i), rng_state[7:0], 1'b0);
        end
        repeat (4) @(posedge clock);
        frame_check.final_check();
        if (frame_check.frames_checked != frames_sent) begin
            $display("%0d frames sent but %0d decoded", frames_sent,
                     frame_check.frames_checked);
            bench_errors++;
        end
        $display("frames %0d, monitor errors %0d, bench errors %0d",
                 frame_check.frames_checked, frame_check.error_count, bench_errors);
        if (frame_check.error_count + bench_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // run limit from the number of frames
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the frames did not finish", cycle_count);
        $display("sim failed");
        $finish;
    end

endmodule

// File: bench/uart_golden.txt
# columns: test name, character in hex, repeat flag
# repeat flag 1 sends a second partida pulse in mid-frame
letter_A 41 0
letter_z 7a 0
digit_0 30 0
space 20 0
all_zero 00 0
all_ones ff 0
alt_55 55 0
alt_aa aa 0
tilde 7e 0
newline 0a 0
carriage_ret 0d 0
repeat_U 55 1
repeat_q 71 1
repeat_zero 00 1
repeat_ff ff 1
msb_only 80 0
lsb_only 01 0
delete 7f 0
at_sign 40 0
percent 25 1

// File: bench/uart_monitor.sv
`timescale 1ns/10ps

module uart_monitor #(
    parameter int M = 16
) (
    input logic            clock,
    input logic            arst_n,
    input logic            partida,
    input logic            saida_serial,
    input logic            pronto,
    input logic            db_tick,
    input logic            db_partida,
    input logic            db_saida_serial,
    input uart_pkg::seg7_t db_estado
);

    import uart_pkg::*;

    // active-low patterns, segments gfedcba
    localparam seg7_t seg_inicial    = 7'b1000000;  // digit 0
    localparam seg7_t seg_preparacao = 7'b1111001;  // digit 1
    localparam seg7_t seg_final_tx   = 7'b0001110;  // letter F

    // partida cycle, ten bits of M clocks, then preparacao and final_tx
    localparam int pronto_delay = 1 + 10 * M + 2;

    string  exp_names[$];
    ascii_t exp_values[$];
    int     error_count = 0;
    int     frames_checked = 0;

    int     cyc = 0;
    bit     busy = 0;
    bit     in_frame = 0;
    int     accept_cyc = 0;
    int     sample_cyc = 0;
    int     bit_idx = 0;
    ascii_t shift;
    string  cur_name = "none";
    ascii_t cur_value;

    task automatic expect_frame(input string name, input ascii_t value);
        exp_names.push_back(name);
        exp_values.push_back(value);
    endtask

    task automatic compare(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s %s: expected %0h, actual %0h", cur_name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic final_check();
        if (busy || in_frame) begin
            $display("a frame was still in progress when the run ended");
            error_count++;
        end
        if (exp_names.size() != 0) begin
            $display("%0d expected frames were never started", exp_names.size());
            error_count++;
        end
    endtask

    // sampled on the falling edge, where the registered outputs are settled
    always @(negedge clock) begin
        if (!arst_n) begin
            busy     = 0;
            in_frame = 0;
            if (saida_serial !== 1'b1 || pronto !== 1'b0 || db_estado !== seg_inicial) begin
                $display("outputs not at their idle values during reset");
                error_count++;
            end
        end else begin
            cyc++;
            if (busy && cyc == accept_cyc + 1) begin
                compare("state after partida", seg_preparacao, db_estado);
            end
            // debug copies follow the signals they mirror
            compare("db_partida", partida, db_partida);
            compare("db_saida_serial", saida_serial, db_saida_serial);
            // tick in the last clock of every M-clock period after the load
            if (busy && cyc - accept_cyc >= 2) begin
                compare("db_tick", ((cyc - accept_cyc - 1) % M) == 0, db_tick);
            end
            if (!busy && db_estado !== seg_inicial) begin
                $display("state left inicial with no partida accepted");
                error_count++;
            end
            // a start only counts while the FSM shows inicial
            if (partida === 1'b1 && !busy && db_estado === seg_inicial) begin
                if (exp_names.size() == 0) begin
                    $display("partida accepted with no expected byte queued");
                    error_count++;
                    cur_name  = "unknown";
                    cur_value = 'x;
                end else begin
                    cur_name  = exp_names.pop_front();
                    cur_value = exp_values.pop_front();
                end
                busy       = 1;
                accept_cyc = cyc;
            end
            if (!in_frame) begin
                if (saida_serial !== 1'b1) begin
                    if (!busy) begin
                        $display("line dropped from idle with no frame started");
                        error_count++;
                    end else begin
                        compare("start edge cycle", accept_cyc + 2, cyc);
                    end
                    in_frame   = 1;
                    bit_idx    = 0;
                    sample_cyc = cyc + M / 2;
                end
            end else if (cyc == sample_cyc) begin
                if (bit_idx == 0) begin
                    compare("start bit", 0, saida_serial);
                end else if (bit_idx <= 8) begin
                    // lsb arrives first
                    shift = {saida_serial, shift[7:1]};
                end else begin
                    compare("stop bit", 1, saida_serial);
                    compare("data", cur_value, shift);
                    frames_checked++;
                    in_frame = 0;
                end
                bit_idx++;
                sample_cyc += M;
            end
            if (pronto === 1'b1) begin
                if (!busy) begin
                    $display("pronto seen with no frame in progress");
                    error_count++;
                end else begin
                    compare("pronto delay", pronto_delay, cyc - accept_cyc);
                    compare("line at pronto", 1, saida_serial);
                    compare("state at pronto", seg_final_tx, db_estado);
                    busy = 0;
                end
            end else if (busy && cyc - accept_cyc > pronto_delay) begin
                $display("pronto missing for test %s", cur_name);
                error_count++;
                busy = 0;
            end
        end
    end

endmodule

// File: build.f
src/uart_pkg.sv
src/contador_m.sv
src/uart_fd.sv
src/uart_uc.sv
src/hexa7seg.sv
src/uart.sv
bench/uart_monitor.sv
bench/tb_uart.sv

// File: src/contador_m.sv
`timescale 1ns/10ps

module contador_m #(
    parameter int M = 434,
    parameter int N = 9
) (
    input  logic         clock,
    input  logic         arst_n,
    input  logic         zera_s,
    output logic [N-1:0] q,
    output logic         fim
);

    // last value before the wrap
    localparam logic [N-1:0] last_count = N'(M - 1);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            q <= '0;
        end else if (zera_s) begin
            q <= '0;
        end else if (q == last_count) begin
            q <= '0;
        end else begin
            q <= q + 1'b1;
        end
    end

    // one strobe per period, during the last count
    assign fim = (q == last_count);

    // the wrap must keep the count inside 0..M-1
    a_q_below_m: assert property (
        @(posedge clock) disable iff (!arst_n)
        q < M
    ) else $error("contador_m: count reached %0d with M = %0d", q, M);

endmodule

// File: src/hexa7seg.sv
`timescale 1ns/10ps

module hexa7seg (
    input  logic [3:0]     codigo,
    output uart_pkg::seg7_t display
);

    // active low, segments gfedcba
    always_comb begin
        case (codigo)
            4'h0: display = 7'b1000000;
            4'h1: display = 7'b1111001;
            4'h2: display = 7'b0100100;
            4'h3: display = 7'b0110000;
            4'h4: display = 7'b0011001;
            4'h5: display = 7'b0010010;
            4'h6: display = 7'b0000010;
            4'h7: display = 7'b1111000;
            4'h8: display = 7'b0000000;
            4'h9: display = 7'b0010000;
            // letters A b C d E F
            4'hA: display = 7'b0001000;
            4'hB: display = 7'b0000011;
            4'hC: display = 7'b1000110;
            4'hD: display = 7'b0100001;
            4'hE: display = 7'b0000110;
            4'hF: display = 7'b0001110;
            default: display = 7'b1111111;
        endcase
    end

endmodule

// File: src/uart.sv
`timescale 1ns/10ps

module uart #(
    // tick period in clocks: 434 = 50 MHz / 115200 baud
    parameter int M = 434,
    parameter int N = 9
) (
    input  logic            clock,
    input  logic            arst_n,
    input  logic            partida,
    input  uart_pkg::ascii_t dados_ascii,
    output logic            saida_serial,
    output logic            pronto,
    output logic            db_tick,
    output logic            db_partida,
    output logic            db_saida_serial,
    output uart_pkg::seg7_t  db_estado
);

    import uart_pkg::*;

    logic        s_zera;
    logic        s_carrega;
    logic        s_desloca;
    logic        s_conta;
    logic        s_tick;
    logic        s_fim;
    logic        s_saida_serial;
    uart_state_t s_estado;

    // datapath
    uart_fd U1_FD (
        .clock        (clock),
        .arst_n       (arst_n),
        .zera         (s_zera),
        .carrega      (s_carrega),
        .desloca      (s_desloca),
        .conta        (s_conta),
        .dados_ascii  (dados_ascii),
        .saida_serial (s_saida_serial),
        .fim          (s_fim)
    );

    // control unit
    uart_uc U2_UC (
        .clock   (clock),
        .arst_n  (arst_n),
        .partida (partida),
        .tick    (s_tick),
        .fim     (s_fim),
        .zera    (s_zera),
        .carrega (s_carrega),
        .desloca (s_desloca),
        .conta   (s_conta),
        .pronto  (pronto),
        .estado  (s_estado)
    );

    // baud tick, restarted with each frame load
    contador_m #(
        .M (M),
        .N (N)
    ) U3_TICK (
        .clock  (clock),
        .arst_n (arst_n),
        .zera_s (s_zera),
        .q      (),
        .fim    (s_tick)
    );

    // state code on the debug display
    hexa7seg U4_HEX (
        .codigo  (s_estado),
        .display (db_estado)
    );

    assign saida_serial = s_saida_serial;

    // debug copies
    assign db_tick         = s_tick;
    assign db_partida      = partida;
    assign db_saida_serial = s_saida_serial;

endmodule

// File: src/uart_fd.sv
`timescale 1ns/10ps

module uart_fd (
    input  logic            clock,
    input  logic            arst_n,
    input  logic            zera,
    input  logic            carrega,
    input  logic            desloca,
    input  logic            conta,
    input  uart_pkg::ascii_t dados_ascii,
    output logic            saida_serial,
    output logic            fim
);

    import uart_pkg::*;

    frame_t     frame;
    bit_count_t bit_count;
    bit_count_t bit_count_next;

    // frame shift register, idles at the line level
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            frame <= {frame_width{idle_level}};
        end else if (carrega) begin
            frame <= {stop_bit, dados_ascii, start_bit};
        end else if (desloca) begin
            // shift right, refill with idle so the line stays high after the stop bit
            frame <= {idle_level, frame[frame_width-1:1]};
        end
    end

    assign saida_serial = frame[0];

    // bits sent so far
    always_comb begin
        if (zera) begin
            bit_count_next = '0;
        end else if (conta) begin
            bit_count_next = bit_count + 1'b1;
        end else begin
            bit_count_next = bit_count;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            bit_count <= '0;
        end else begin
            bit_count <= bit_count_next;
        end
    end

    // looks at the count after this cycle, so the shift that
    // completes the frame already sees fim and the level holds after it
    assign fim = (bit_count_next == count_width'(frame_bits));

    // control unit must never load and shift in the same cycle
    a_load_or_shift: assert property (
        @(posedge clock) disable iff (!arst_n)
        !(carrega && desloca)
    ) else $error("uart_fd: carrega and desloca high together");

endmodule

// File: src/uart_pkg.sv
package uart_pkg;

    // widths that carry a meaning across the design
    localparam int unsigned ascii_width = 8;
    localparam int unsigned frame_width = 10;
    localparam int unsigned count_width = 4;
    localparam int unsigned seg7_width  = 7;

    // one character as it enters the transmitter
    typedef logic [ascii_width-1:0] ascii_t;

    // whole frame held in the shift register, bit 0 goes out first
    typedef logic [frame_width-1:0] frame_t;

    // bits already sent in the current frame
    typedef logic [count_width-1:0] bit_count_t;

    // active-low segment pattern, bit order gfedcba
    typedef logic [seg7_width-1:0] seg7_t;

    // frame layout
    localparam int unsigned frame_bits = 10;
    localparam logic        start_bit  = 1'b0;
    localparam logic        stop_bit   = 1'b1;
    // line level between frames
    localparam logic        idle_level = 1'b1;

    // control states; the code is also shown on the debug display
    typedef enum logic [3:0] {
        inicial     = 4'h0,
        preparacao  = 4'h1,
        espera      = 4'h2,
        transmissao = 4'h3,
        final_tx    = 4'hF
    } uart_state_t;

endpackage

// File: src/uart_uc.sv
`timescale 1ns/10ps

module uart_uc (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 partida,
    input  logic                 tick,
    input  logic                 fim,
    output logic                 zera,
    output logic                 carrega,
    output logic                 desloca,
    output logic                 conta,
    output logic                 pronto,
    output uart_pkg::uart_state_t estado
);

    import uart_pkg::*;

    uart_state_t state;
    uart_state_t state_next;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= inicial;
        end else begin
            state <= state_next;
        end
    end

    // next state
    always_comb begin
        state_next = state;
        case (state)
            inicial: begin
                // partida only counts while idle
                if (partida) begin
                    state_next = preparacao;
                end
            end
            preparacao: begin
                state_next = espera;
            end
            espera: begin
                if (tick) begin
                    state_next = transmissao;
                end
            end
            transmissao: begin
                if (fim) begin
                    state_next = final_tx;
                end else begin
                    state_next = espera;
                end
            end
            final_tx: begin
                state_next = inicial;
            end
            default: begin
                state_next = inicial;
            end
        endcase
    end

    // Moore outputs, from the state alone
    always_comb begin
        zera    = 1'b0;
        carrega = 1'b0;
        desloca = 1'b0;
        conta   = 1'b0;
        pronto  = 1'b0;
        case (state)
            preparacao: begin
                // load the frame and restart both counters together
                zera    = 1'b1;
                carrega = 1'b1;
            end
            transmissao: begin
                desloca = 1'b1;
                conta   = 1'b1;
            end
            final_tx: begin
                pronto = 1'b1;
            end
            default: begin
                zera = 1'b0;
            end
        endcase
    end

    assign estado = state;

    // end of frame is a single-cycle pulse
    a_pronto_pulse: assert property (
        @(posedge clock) disable iff (!arst_n)
        pronto |=> !pronto
    ) else $error("uart_uc: pronto held for more than one cycle");

endmodule
